//--- Makefile
# Verilator flow for the PRBS31 generator and checker
# any variable below can be set on the make command line

VERILATOR  ?= verilator
FILELIST   ?= prbs_top.f
RTL_TOP    ?= prbs_top
TB_TOP     ?= prbs_tb
BUILD_DIR  ?= obj_dir
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal
PASS_TEXT  ?= sim passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

# the run passes only if the pass line shows up in the output
sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		-Mdir $(BUILD_DIR) -o $(TB_TOP)
	@out="$$(./$(BUILD_DIR)/$(TB_TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

//--- hw/lfsr.sv
//////////////////////////////////////////////////
// combinational parallel LFSR, DATA_WIDTH shifts per pass
// masks are constant, logic folds to XOR trees
// MSB first unless REVERSE is set
//////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module lfsr #(
    // register length
    parameter int LFSR_WIDTH = 31,
    // polynomial with the top term left out
    parameter logic [LFSR_WIDTH-1:0] LFSR_POLY = 31'h10000001,
    // "FIBONACCI" or "GALOIS"
    parameter LFSR_CONFIG = "FIBONACCI",
    // nonzero for the self-synchronizing form
    parameter int LFSR_FEED_FORWARD = 0,
    // nonzero for LSB first
    parameter int REVERSE = 0,
    parameter int DATA_WIDTH = 8
) (
    input  logic [DATA_WIDTH-1:0] data_in,
    input  logic [LFSR_WIDTH-1:0] state_in,
    output logic [DATA_WIDTH-1:0] data_out,
    output logic [LFSR_WIDTH-1:0] state_out
);

    // per next-state bit, which state and data bits feed it
    logic [LFSR_WIDTH-1:0] mask_state     [LFSR_WIDTH];
    logic [DATA_WIDTH-1:0] mask_data      [LFSR_WIDTH];
    // per output bit, same idea
    logic [LFSR_WIDTH-1:0] out_mask_state [DATA_WIDTH];
    logic [DATA_WIDTH-1:0] out_mask_data  [DATA_WIDTH];
    // symbolic value entering stage 0
    logic [LFSR_WIDTH-1:0] fb_state;
    logic [DATA_WIDTH-1:0] fb_data;

    initial begin
        assert (LFSR_WIDTH > 1 && DATA_WIDTH > 0 &&
                (LFSR_CONFIG == "FIBONACCI" || LFSR_CONFIG == "GALOIS"))
            else $error("lfsr: bad width or config parameter");
    end

    // symbolic run of the shift register over one word
    always_comb begin
        fb_state = '0;
        fb_data  = '0;
        // each stage starts as itself
        for (int i = 0; i < LFSR_WIDTH; i++) begin
            mask_state[i]    = '0;
            mask_state[i][i] = 1'b1;
            mask_data[i]     = '0;
        end
        for (int i = 0; i < DATA_WIDTH; i++) begin
            out_mask_state[i] = '0;
            if (i < LFSR_WIDTH) begin
                out_mask_state[i][i] = 1'b1;
            end
            out_mask_data[i] = '0;
        end
        for (int i = DATA_WIDTH - 1; i >= 0; i--) begin
            // last stage plus data bit i
            fb_state    = mask_state[LFSR_WIDTH-1];
            fb_data     = mask_data[LFSR_WIDTH-1];
            fb_data[i]  = ~fb_data[i];
            // fibonacci taps fold into the fed-back bit
            if (LFSR_CONFIG == "FIBONACCI") begin
                for (int j = 1; j < LFSR_WIDTH; j++) begin
                    if (LFSR_POLY[j]) begin
                        fb_state = fb_state ^ mask_state[j-1];
                        fb_data  = fb_data ^ mask_data[j-1];
                    end
                end
            end
            for (int j = LFSR_WIDTH - 1; j > 0; j--) begin
                mask_state[j] = mask_state[j-1];
                mask_data[j]  = mask_data[j-1];
            end
            for (int j = DATA_WIDTH - 1; j > 0; j--) begin
                out_mask_state[j] = out_mask_state[j-1];
                out_mask_data[j]  = out_mask_data[j-1];
            end
            out_mask_state[0] = fb_state;
            out_mask_data[0]  = fb_data;
            // feed-forward: register holds raw input only
            if (LFSR_FEED_FORWARD != 0) begin
                fb_state   = '0;
                fb_data    = '0;
                fb_data[i] = 1'b1;
            end
            mask_state[0] = fb_state;
            mask_data[0]  = fb_data;
            // galois taps land inside the register
            if (LFSR_CONFIG == "GALOIS") begin
                for (int j = 1; j < LFSR_WIDTH; j++) begin
                    if (LFSR_POLY[j]) begin
                        mask_state[j] = mask_state[j] ^ fb_state;
                        mask_data[j]  = mask_data[j] ^ fb_data;
                    end
                end
            end
        end
        if (REVERSE != 0) begin
            // swap stage order, then bit order inside each mask
            for (int i = 0; i < LFSR_WIDTH / 2; i++) begin
                fb_state                   = mask_state[i];
                fb_data                    = mask_data[i];
                mask_state[i]              = mask_state[LFSR_WIDTH-1-i];
                mask_data[i]               = mask_data[LFSR_WIDTH-1-i];
                mask_state[LFSR_WIDTH-1-i] = fb_state;
                mask_data[LFSR_WIDTH-1-i]  = fb_data;
            end
            for (int i = 0; i < DATA_WIDTH / 2; i++) begin
                fb_state                       = out_mask_state[i];
                fb_data                        = out_mask_data[i];
                out_mask_state[i]              = out_mask_state[DATA_WIDTH-1-i];
                out_mask_data[i]               = out_mask_data[DATA_WIDTH-1-i];
                out_mask_state[DATA_WIDTH-1-i] = fb_state;
                out_mask_data[DATA_WIDTH-1-i]  = fb_data;
            end
            for (int i = 0; i < LFSR_WIDTH; i++) begin
                mask_state[i] = {<<{mask_state[i]}};
                mask_data[i]  = {<<{mask_data[i]}};
            end
            for (int i = 0; i < DATA_WIDTH; i++) begin
                out_mask_state[i] = {<<{out_mask_state[i]}};
                out_mask_data[i]  = {<<{out_mask_data[i]}};
            end
        end
    end

    // XOR of the bits each mask selects, nested loop form
    always_comb begin
        state_out = '0;
        data_out  = '0;
        for (int n = 0; n < LFSR_WIDTH; n++) begin
            for (int m = 0; m < LFSR_WIDTH; m++) begin
                if (mask_state[n][m]) begin
                    state_out[n] = state_out[n] ^ state_in[m];
                end
            end
            for (int m = 0; m < DATA_WIDTH; m++) begin
                if (mask_data[n][m]) begin
                    state_out[n] = state_out[n] ^ data_in[m];
                end
            end
        end
        for (int n = 0; n < DATA_WIDTH; n++) begin
            for (int m = 0; m < LFSR_WIDTH; m++) begin
                if (out_mask_state[n][m]) begin
                    data_out[n] = data_out[n] ^ state_in[m];
                end
            end
            for (int m = 0; m < DATA_WIDTH; m++) begin
                if (out_mask_data[n][m]) begin
                    data_out[n] = data_out[n] ^ data_in[m];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/prbs_check.sv
//////////////////////////////////////////////////
// self-synchronizing PRBS31 checker
// one flipped line bit counts as three errors
// errors before lock are not counted
//////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none
`include "prbs_defines.svh"

module prbs_check (
    input  logic                        clk,
    input  logic                        rst_n,
    prbs_ctrl_if.check                  ctrl_bus,
    input  logic [`PRBS_DATA_WIDTH-1:0] rx_data,
    input  logic                        rx_valid
);

    localparam int RUN_W = $clog2(`PRBS_LOCK_WORDS + 1);
    localparam int POP_W = $clog2(`PRBS_DATA_WIDTH + 1);

    logic [`PRBS_WIDTH-1:0]      history;
    logic [`PRBS_WIDTH-1:0]      history_next;
    logic [`PRBS_DATA_WIDTH-1:0] residue;
    logic [RUN_W-1:0]            run_cnt;
    logic [POP_W-1:0]            err_bits;
    logic [`PRBS_CNT_WIDTH:0]    err_sum;
    logic [`PRBS_CNT_WIDTH-1:0]  err_count_q;
    logic                        lock_q;
    logic                        word_en;

    assign word_en = rx_valid && ctrl_bus.ctrl.check_enable;

    // history is the last 31 line bits, residue is zero on a clean word
    lfsr #(
        .LFSR_WIDTH       (`PRBS_WIDTH),
        .LFSR_POLY        (`PRBS_POLY),
        .LFSR_CONFIG      ("FIBONACCI"),
        .LFSR_FEED_FORWARD(1),
        .REVERSE          (0),
        .DATA_WIDTH       (`PRBS_DATA_WIDTH)
    ) u_lfsr (
        .data_in  (rx_data),
        .state_in (history),
        .data_out (residue),
        .state_out(history_next)
    );

    // popcount of the residue
    always_comb begin
        err_bits = '0;
        for (int i = 0; i < `PRBS_DATA_WIDTH; i++) begin
            err_bits = err_bits + POP_W'(residue[i]);
        end
    end

    // one spare bit catches the overflow
    assign err_sum = {1'b0, err_count_q} + (`PRBS_CNT_WIDTH + 1)'(err_bits);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            history <= '0;
            run_cnt <= '0;
            lock_q  <= 1'b0;
        end else if (!ctrl_bus.ctrl.check_enable) begin
            run_cnt <= '0;
            lock_q  <= 1'b0;
        end else if (rx_valid) begin
            history <= history_next;
            if (residue != '0) begin
                run_cnt <= '0;
            end else if (run_cnt != RUN_W'(`PRBS_LOCK_WORDS)) begin
                run_cnt <= run_cnt + 1'b1;
            end
            // lock is sticky until the checker is disabled
            if (residue == '0 && run_cnt == RUN_W'(`PRBS_LOCK_WORDS - 1)) begin
                lock_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            err_count_q <= '0;
        end else if (ctrl_bus.clear) begin
            err_count_q <= '0;
        end else if (word_en && lock_q) begin
            // saturate at all ones
            if (err_sum[`PRBS_CNT_WIDTH]) begin
                err_count_q <= '1;
            end else begin
                err_count_q <= err_sum[`PRBS_CNT_WIDTH-1:0];
            end
        end
    end

    assign ctrl_bus.err_count = err_count_q;
    assign ctrl_bus.lock      = lock_q;

    // count only drops on a clear strobe from the register block
    assert property (@(posedge clk) disable iff (!rst_n)
        !$past(ctrl_bus.clear) |-> err_count_q >= $past(err_count_q));

endmodule

`default_nettype wire

//--- hw/prbs_ctrl_if.sv
//////////////////////////////////////////////////
// control and status between registers and datapath
// inject and clear are single-cycle pulses
//////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none
`include "prbs_defines.svh"

interface prbs_ctrl_if;

    prbs_pkg::ctrl_t             ctrl;
    logic                        inject;
    logic                        clear;
    logic [`PRBS_CNT_WIDTH-1:0]  err_count;
    logic                        lock;

    modport regs  (output ctrl, inject, clear, input err_count, lock);
    // generator only looks at ctrl.gen_enable
    modport gen   (input ctrl, inject);
    // checker only looks at ctrl.check_enable
    modport check (input ctrl, clear, output err_count, lock);

endinterface

`default_nettype wire

//--- hw/prbs_defines.svh
//////////////////////////////////////////////////
// PRBS31 build constants, one value per design
// counter width must not exceed the 16-bit read port
//////////////////////////////////////////////////
`ifndef PRBS_DEFINES_SVH
`define PRBS_DEFINES_SVH

// bits per word on the tx and rx sides
`define PRBS_DATA_WIDTH 8

// x^31 + x^28 + 1, top term implied by the width
`define PRBS_WIDTH 31
`define PRBS_POLY 31'h10000001

// generator state after reset, any nonzero value works
`define PRBS_SEED {`PRBS_WIDTH{1'b1}}

// clean words before the checker declares lock
`define PRBS_LOCK_WORDS 8

// saturating bit error counter
`define PRBS_CNT_WIDTH 16

`endif

//--- hw/prbs_gen.sv
//////////////////////////////////////////////////
// free-running PRBS31 source, no back-pressure
// bit 7 of tx_data goes out first
//////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none
`include "prbs_defines.svh"

module prbs_gen (
    input  logic                        clk,
    input  logic                        rst_n,
    prbs_ctrl_if.gen                    ctrl_bus,
    output logic [`PRBS_DATA_WIDTH-1:0] tx_data,
    output logic                        tx_valid
);

    logic [`PRBS_WIDTH-1:0]      state;
    logic [`PRBS_WIDTH-1:0]      state_next;
    logic [`PRBS_DATA_WIDTH-1:0] word;

    // feedback only, data input unused
    lfsr #(
        .LFSR_WIDTH       (`PRBS_WIDTH),
        .LFSR_POLY        (`PRBS_POLY),
        .LFSR_CONFIG      ("FIBONACCI"),
        .LFSR_FEED_FORWARD(0),
        .REVERSE          (0),
        .DATA_WIDTH       (`PRBS_DATA_WIDTH)
    ) u_lfsr (
        .data_in  ({`PRBS_DATA_WIDTH{1'b0}}),
        .state_in (state),
        .data_out (word),
        .state_out(state_next)
    );

    // state holds while disabled
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= `PRBS_SEED;
            tx_valid <= 1'b0;
        end else begin
            tx_valid <= ctrl_bus.ctrl.gen_enable;
            if (ctrl_bus.ctrl.gen_enable) begin
                state <= state_next;
            end
        end
    end

    // injected error only touches the output word, bit 0
    always_ff @(posedge clk) begin
        if (ctrl_bus.ctrl.gen_enable) begin
            tx_data <= word ^ {{(`PRBS_DATA_WIDTH-1){1'b0}}, ctrl_bus.inject};
        end
    end

    // all-zero state would lock the sequence up
    assert property (@(posedge clk) disable iff (!rst_n) state != '0);

endmodule

`default_nettype wire

//--- hw/prbs_pkg.sv
//////////////////////////////////////////////////
// register map types for the PRBS block
// CTRL bits 2 and 3 are write-only strobes
//////////////////////////////////////////////////
`default_nettype none

package prbs_pkg;

    // register addresses, address 3 reads zero
    typedef enum logic [1:0] {
        REG_CTRL      = 2'd0,
        REG_ERR_COUNT = 2'd1,
        REG_STATUS    = 2'd2
    } reg_addr_t;

    // held part of CTRL, gen_enable is bit 0
    typedef struct packed {
        logic check_enable;
        logic gen_enable;
    } ctrl_t;

endpackage

`default_nettype wire

//--- hw/prbs_regs.sv
//////////////////////////////////////////////////
// CTRL/ERR_COUNT/STATUS registers, writes only to CTRL
// strobe writes to CTRL must not come back to back
//////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none
`include "prbs_defines.svh"

module prbs_regs (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                reg_wr_en,
    input  prbs_pkg::reg_addr_t reg_addr,
    input  logic [7:0]          reg_wdata,
    output logic [15:0]         reg_rdata,
    prbs_ctrl_if.regs           ctrl_bus
);

    prbs_pkg::ctrl_t ctrl_q;
    logic            inject_q;
    logic            clear_q;
    logic            ctrl_wr;

    assign ctrl_wr = reg_wr_en && (reg_addr == prbs_pkg::REG_CTRL);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl_q   <= '0;
            inject_q <= 1'b0;
            clear_q  <= 1'b0;
        end else begin
            if (ctrl_wr) begin
                ctrl_q <= prbs_pkg::ctrl_t'(reg_wdata[1:0]);
            end
            // strobes self-clear, one pulse per write
            inject_q <= ctrl_wr && reg_wdata[2];
            clear_q  <= ctrl_wr && reg_wdata[3];
        end
    end

    assign ctrl_bus.ctrl   = ctrl_q;
    assign ctrl_bus.inject = inject_q;
    assign ctrl_bus.clear  = clear_q;

    // read path, unused bits zero
    always_comb begin
        reg_rdata = '0;
        case (reg_addr)
            prbs_pkg::REG_CTRL:      reg_rdata[1:0] = ctrl_q;
            prbs_pkg::REG_ERR_COUNT: reg_rdata[`PRBS_CNT_WIDTH-1:0] = ctrl_bus.err_count;
            prbs_pkg::REG_STATUS:    reg_rdata[0] = ctrl_bus.lock;
            default:                 reg_rdata = '0;
        endcase
    end

    // strobe writes never come back to back
    assert property (@(posedge clk) disable iff (!rst_n) inject_q |=> !inject_q);
    assert property (@(posedge clk) disable iff (!rst_n) clear_q |=> !clear_q);

endmodule

`default_nettype wire

//--- hw/prbs_top.sv
//////////////////////////////////////////////////
// PRBS31 generator and checker with a register port
// single clock, rx side fed externally
//////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none
`include "prbs_defines.svh"

module prbs_top (
    input  logic                        clk,
    input  logic                        rst_n,
    // register port, reads are combinational
    input  logic                        reg_wr_en,
    input  logic [1:0]                  reg_addr,
    input  logic [7:0]                  reg_wdata,
    output logic [15:0]                 reg_rdata,
    // pattern out
    output logic [`PRBS_DATA_WIDTH-1:0] tx_data,
    output logic                        tx_valid,
    // pattern back in
    input  logic [`PRBS_DATA_WIDTH-1:0] rx_data,
    input  logic                        rx_valid
);

    prbs_ctrl_if ctrl_bus ();

    prbs_regs u_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .reg_wr_en(reg_wr_en),
        .reg_addr (prbs_pkg::reg_addr_t'(reg_addr)),
        .reg_wdata(reg_wdata),
        .reg_rdata(reg_rdata),
        .ctrl_bus (ctrl_bus.regs)
    );

    prbs_gen u_gen (
        .clk     (clk),
        .rst_n   (rst_n),
        .ctrl_bus(ctrl_bus.gen),
        .tx_data (tx_data),
        .tx_valid(tx_valid)
    );

    prbs_check u_check (
        .clk     (clk),
        .rst_n   (rst_n),
        .ctrl_bus(ctrl_bus.check),
        .rx_data (rx_data),
        .rx_valid(rx_valid)
    );

endmodule

`default_nettype wire

//--- prbs_top.f
+incdir+hw
hw/prbs_pkg.sv
hw/lfsr.sv
hw/prbs_ctrl_if.sv
hw/prbs_regs.sv
hw/prbs_gen.sv
hw/prbs_check.sv
hw/prbs_top.sv
verification/prbs_monitor.sv
verification/prbs_tb.sv

//--- verification/prbs_monitor.sv
//////////////////////////////////////////////////
// watches the PRBS block ports and compares them
// with serial PRBS31 and checker models
// assumes writes to CTRL are never back to back
//////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none
`include "prbs_defines.svh"

module prbs_monitor (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        reg_wr_en,
    input  logic [1:0]                  reg_addr,
    input  logic [7:0]                  reg_wdata,
    input  logic [15:0]                 reg_rdata,
    input  logic [`PRBS_DATA_WIDTH-1:0] tx_data,
    input  logic                        tx_valid,
    input  logic [`PRBS_DATA_WIDTH-1:0] rx_data,
    input  logic                        rx_valid,
    // read strobe and expected value from the stimulus file
    input  logic                        rd_check,
    input  logic [15:0]                 rd_expect,
    output int                          error_count,
    output int                          check_count
);

    localparam int COUNT_MAX = (1 << `PRBS_CNT_WIDTH) - 1;

    // register model, ctrl is {check_enable, gen_enable}
    logic [1:0]             ctrl;
    logic                   inject;
    logic                   clear;
    // what the next tx word should look like
    logic                   valid_exp;
    logic                   inject_exp;
    // serial generator and checker models
    logic [`PRBS_WIDTH-1:0] gen_state;
    logic [`PRBS_WIDTH-1:0] rx_hist;
    int                     run_len;
    logic                   lock;
    int                     count;

    task automatic check_value(input string name, input logic [15:0] exp_val,
                               input logic [15:0] act_val);
        check_count = check_count + 1;
        if (act_val !== exp_val) begin
            error_count = error_count + 1;
            $display("** Error %s: expected %h, actual %h at %0t ns",
                     name, exp_val, act_val, $time);
        end
    endtask

    // compare with pre-edge values, then step the models
    always @(posedge clk) begin
        logic [7:0] word;
        logic       new_bit;
        logic       line_bit;
        int         errs;
        int         sum;
        if (!rst_n) begin
            ctrl        = '0;
            inject      = 1'b0;
            clear       = 1'b0;
            valid_exp   = 1'b0;
            inject_exp  = 1'b0;
            gen_state   = `PRBS_SEED;
            rx_hist     = '0;
            run_len     = 0;
            lock        = 1'b0;
            count       = 0;
            error_count = 0;
            check_count = 0;
        end else begin
            check_value("tx_valid", 16'(valid_exp), 16'(tx_valid));
            if (tx_valid) begin
                // x^31 + x^28 + 1, first bit in time lands in bit 7
                for (int i = 7; i >= 0; i--) begin
                    new_bit   = gen_state[30] ^ gen_state[27];
                    gen_state = {gen_state[29:0], new_bit};
                    word[i]   = new_bit;
                end
                word[0] = word[0] ^ inject_exp;
                check_value("tx_data", 16'(word), 16'(tx_data));
            end
            if (rd_check) begin
                check_value("reg_rdata", rd_expect, reg_rdata);
                if (reg_addr == prbs_pkg::REG_CTRL) begin
                    check_value("ctrl", 16'(ctrl), reg_rdata);
                end else if (reg_addr == prbs_pkg::REG_ERR_COUNT) begin
                    check_value("err_count", 16'(count), reg_rdata);
                end else if (reg_addr == prbs_pkg::REG_STATUS) begin
                    check_value("lock", 16'(lock), reg_rdata);
                end
            end
            // residue bit is the line bit against taps 28 and 31 back
            errs = 0;
            if (ctrl[1] && rx_valid) begin
                for (int i = 7; i >= 0; i--) begin
                    line_bit = rx_data[i];
                    errs     = errs + int'(line_bit ^ rx_hist[30] ^ rx_hist[27]);
                    rx_hist  = {rx_hist[29:0], line_bit};
                end
            end
            // counting uses the lock state before this word
            if (clear) begin
                count = 0;
            end else if (ctrl[1] && rx_valid && lock) begin
                sum   = count + errs;
                count = (sum > COUNT_MAX) ? COUNT_MAX : sum;
            end
            if (!ctrl[1]) begin
                run_len = 0;
                lock    = 1'b0;
            end else if (rx_valid) begin
                if (errs == 0) begin
                    run_len = run_len + 1;
                    if (run_len >= `PRBS_LOCK_WORDS) begin
                        lock = 1'b1;
                    end
                end else begin
                    run_len = 0;
                end
            end
            valid_exp  = ctrl[0];
            inject_exp = inject;
            // register writes show one cycle after the edge
            if (reg_wr_en && reg_addr == prbs_pkg::REG_CTRL) begin
                ctrl   = reg_wdata[1:0];
                inject = reg_wdata[2];
                clear  = reg_wdata[3];
            end else begin
                inject = 1'b0;
                clear  = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- verification/prbs_stimulus.txt
# columns: command, then address and data or expected value in hex
# write A D | read A E | run N (tx words, decimal) | flip (one line bit)
# after reset
read 1 0000
read 2 0000
# generator on, then frozen, then resumed
write 0 01
run 20
write 0 00
read 0 0000
read 0 0000
write 0 01
run 10
# checker on, lock within lock words plus three
write 0 03
run 11
read 2 0001
read 1 0000
run 4
read 1 0000
# inject strobe, one bit gives three errors
write 0 07
run 8
read 1 0003
read 0 0003
# loopback flips, three errors each
flip
run 6
read 1 0006
flip
run 6
flip
run 6
read 1 000c
# clear keeps lock, checker off drops it
write 0 0b
read 1 0000
read 2 0001
write 0 01
read 2 0000
write 0 00

//--- verification/prbs_tb.sv
//////////////////////////////////////////////////
// PRBS31 testbench, stimulus from a text file
// loopback with one register stage
//////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none
`include "prbs_defines.svh"

module prbs_tb;

    localparam int CLK_PERIOD   = 40;
    // idle cycles allowed while waiting for one word
    localparam int WORD_TIMEOUT = 50;

    logic                        clk;
    logic                        rst_n;
    logic                        reg_wr_en;
    logic [1:0]                  reg_addr;
    logic [7:0]                  reg_wdata;
    logic [15:0]                 reg_rdata;
    logic [`PRBS_DATA_WIDTH-1:0] tx_data;
    logic                        tx_valid;
    logic [`PRBS_DATA_WIDTH-1:0] rx_data = '0;
    logic                        rx_valid = 1'b0;
    logic                        rd_check;
    logic [15:0]                 rd_expect;
    logic [`PRBS_DATA_WIDTH-1:0] flip_mask;
    logic [31:0]                 rng;
    int                          error_count;
    int                          check_count;
    int                          failures;
    int                          fd;

    prbs_top UUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .reg_wr_en(reg_wr_en),
        .reg_addr (reg_addr),
        .reg_wdata(reg_wdata),
        .reg_rdata(reg_rdata),
        .tx_data  (tx_data),
        .tx_valid (tx_valid),
        .rx_data  (rx_data),
        .rx_valid (rx_valid)
    );

    prbs_monitor u_monitor (
        .clk        (clk),
        .rst_n      (rst_n),
        .reg_wr_en  (reg_wr_en),
        .reg_addr   (reg_addr),
        .reg_wdata  (reg_wdata),
        .reg_rdata  (reg_rdata),
        .tx_data    (tx_data),
        .tx_valid   (tx_valid),
        .rx_data    (rx_data),
        .rx_valid   (rx_valid),
        .rd_check   (rd_check),
        .rd_expect  (rd_expect),
        .error_count(error_count),
        .check_count(check_count)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // loopback, flip_mask corrupts the word passing through
    always @(posedge clk) begin
        if (!rst_n) begin
            rx_data  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_data  <= tx_data ^ flip_mask;
            rx_valid <= tx_valid;
        end
    end

    // x^32 + x^22 + x^2 + x + 1, new bit enters at bit 0
    function automatic logic [31:0] rand_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic write_reg(input logic [1:0] addr, input logic [7:0] data);
        @(posedge clk);
        reg_wr_en <= 1'b1;
        reg_addr  <= addr;
        reg_wdata <= data;
        @(posedge clk);
        reg_wr_en <= 1'b0;
    endtask

    // monitor samples reg_rdata on the edge after the address
    task automatic read_reg(input logic [1:0] addr, input logic [15:0] expect_val);
        @(posedge clk);
        reg_addr  <= addr;
        rd_check  <= 1'b1;
        rd_expect <= expect_val;
        @(posedge clk);
        rd_check  <= 1'b0;
    endtask

    task automatic run_words(input int n);
        int got;
        int idle;
        got  = 0;
        idle = 0;
        while (got < n && idle < WORD_TIMEOUT) begin
            @(posedge clk);
            if (tx_valid) begin
                got  = got + 1;
                idle = 0;
            end else begin
                idle = idle + 1;
            end
        end
        if (got < n) begin
            $display("timeout: generator gave only %0d of %0d words", got, n);
            failures = failures + 1;
        end
    endtask

    // one line bit flipped, index from three rng bits
    task automatic flip_word();
        logic [2:0] idx;
        idx = '0;
        for (int i = 0; i < 3; i++) begin
            rng = rand_step(rng);
            idx = {idx[1:0], rng[0]};
        end
        @(posedge clk);
        flip_mask <= 8'(1) << idx;
        @(posedge clk);
        flip_mask <= '0;
    endtask

    initial begin
        logic [8*8-1:0]  cmd;
        logic [8*80-1:0] rest;
        logic [15:0]     arg_a;
        logic [15:0]     arg_b;
        int              n;
        int              code;
        rst_n     = 1'b0;
        reg_wr_en = 1'b0;
        reg_addr  = '0;
        reg_wdata = '0;
        rd_check  = 1'b0;
        rd_expect = '0;
        flip_mask = '0;
        rng       = 32'd97172;
        failures  = 0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        fd = $fopen("verification/prbs_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file");
            failures = failures + 1;
        end else begin
            while (failures == 0 && !$feof(fd)) begin
                code = $fscanf(fd, "%s", cmd);
                if (code == 1) begin
                    if (cmd == 64'("#")) begin
                        code = $fgets(rest, fd);
                    end else if (cmd == 64'("write")) begin
                        code = $fscanf(fd, "%h %h", arg_a, arg_b);
                        write_reg(arg_a[1:0], arg_b[7:0]);
                    end else if (cmd == 64'("read")) begin
                        code = $fscanf(fd, "%h %h", arg_a, arg_b);
                        read_reg(arg_a[1:0], arg_b);
                    end else if (cmd == 64'("run")) begin
                        code = $fscanf(fd, "%d", n);
                        run_words(n);
                    end else if (cmd == 64'("flip")) begin
                        flip_word();
                    end else begin
                        $display("unknown command in the stimulus file");
                        failures = failures + 1;
                    end
                end
            end
            $fclose(fd);
        end
        repeat (2) @(posedge clk);
        $display("checks %0d, errors %0d, other failures %0d",
                 check_count, error_count, failures);
        if (error_count == 0 && failures == 0 && check_count > 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
